//--- sources.f
+incdir+hdl
hdl/ralloc_pkg.sv
hdl/lzp.sv
hdl/busy_bitmap.sv
hdl/rename_table.sv
hdl/ralloc_ctrl.sv
hdl/ralloc_top.sv
verification/ralloc_chk.sv
verification/ralloc_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module ralloc_tb -Mdir obj_dir -f sources.f
	./obj_dir/Vralloc_tb 2>&1 | tee sim.log
	@if grep -q "Test FAILED" sim.log || ! grep -q "Test OK" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- verification/ralloc_tb.sv
`timescale 1ns/1ns
`include "ralloc_macros.svh"

module ralloc_tb import ralloc_pkg::*; ();

	logic clk_i;
	logic arst_n_i;
	rn_req_t rn_req_i;
	rn_rsp_t rn_rsp_o;
	cm_req_t cm_req_i;
	logic flush_i;
	logic rn_ready_o;

	// reference model of both maps and both bitmaps
	logic [`RALLOC_PHY_CW-1:0] spec_map [`RALLOC_ARCH_N];
	logic [`RALLOC_PHY_CW-1:0] cm_map [`RALLOC_ARCH_N];
	logic [`RALLOC_PHY_N-1:0] spec_busy, cm_busy;
	logic recover;
	logic [`RALLOC_ARCH_CW-1:0] rob_rd [$]; // renamed and not yet committed, oldest first
	logic [`RALLOC_PHY_CW-1:0] rob_phy [$];

	int checks, errors, tests, failed_tests, test_errors, n;
	logic hung;
	string test_name;

	ralloc_top ralloc_top_i (.*);

	always #4 clk_i = ~clk_i;

	function automatic int lowest_free(input logic [`RALLOC_PHY_N-1:0] busy);
		for (int i = 0; i < `RALLOC_PHY_N; i++) begin
			if (!busy[i]) return i;
		end
		return -1; // every register is taken
	endfunction

	task automatic check(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	// one clock cycle of stimulus, then the response is checked at the falling edge
	task automatic step(input logic v, input logic [`RALLOC_ARCH_CW-1:0] arch_rd, input logic cv,
			input logic [`RALLOC_ARCH_CW-1:0] crd, input logic [`RALLOC_PHY_CW-1:0] cphy,
			input logic fl);
		int free_pos;
		logic exp_ready, exp_ack;
		logic [`RALLOC_PHY_CW-1:0] exp_new, old_cm;
		@(posedge clk_i);
		rn_req_i <= '{valid: v, rd: arch_rd};
		cm_req_i <= '{valid: cv, rd: crd, phy_new: cphy};
		flush_i <= fl;
		@(negedge clk_i);
		free_pos = lowest_free(spec_busy);
		exp_ready = !recover && (free_pos >= 0) && !fl;
		exp_ack = v && exp_ready;
		exp_new = (arch_rd == 0) ? '0 : `RALLOC_PHY_CW'(free_pos); // x0 maps to phy 0
		check("rn_ready_o", int'(rn_ready_o), int'(exp_ready));
		check("rn_rsp_o.ack", int'(rn_rsp_o.ack), int'(exp_ack));
		if (exp_ack) begin
			check("rn_rsp_o.phy_new", int'(rn_rsp_o.phy_new), int'(exp_new));
			check("rn_rsp_o.phy_old", int'(rn_rsp_o.phy_old), int'(spec_map[arch_rd]));
		end
		if (cv) begin
			old_cm = cm_map[crd];
			cm_map[crd] = cphy;
			cm_busy[old_cm] = 1'b0;
			spec_busy[old_cm] = 1'b0;
			cm_busy[cphy] = 1'b1;
		end
		if (fl) begin
			spec_map = cm_map;
			spec_busy = cm_busy;
			recover = 1'b1;
			rob_rd.delete();
			rob_phy.delete();
		end else begin
			recover = 1'b0;
			if (exp_ack && arch_rd != 0) begin
				spec_busy[exp_new] = 1'b1;
				spec_map[arch_rd] = exp_new;
				rob_rd.push_back(arch_rd);
				rob_phy.push_back(exp_new);
			end
		end
	endtask

	task automatic rename(input logic [`RALLOC_ARCH_CW-1:0] arch_rd);
		step(1'b1, arch_rd, 1'b0, '0, '0, 1'b0);
	endtask

	task automatic commit_oldest();
		logic [`RALLOC_ARCH_CW-1:0] crd;
		logic [`RALLOC_PHY_CW-1:0] cphy;
		crd = rob_rd.pop_front();
		cphy = rob_phy.pop_front();
		step(1'b0, '0, 1'b1, crd, cphy, 1'b0);
	endtask

	task automatic wait_ready(input int limit);
		int cnt;
		cnt = 0;
		while (!rn_ready_o && cnt < limit) begin
			step(1'b0, '0, 1'b0, '0, '0, 1'b0);
			cnt++;
		end
		if (!rn_ready_o) begin
			$display("timeout: rn_ready_o stayed low for %0d cycles in %s", limit, test_name);
			hung = 1'b1;
		end
	endtask

	task automatic open_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic close_test();
		tests++;
		if (errors != test_errors || hung) failed_tests++;
		$display("%s: %s, %0d errors", test_name, (errors != test_errors || hung) ? "FAIL" : "PASS",
			errors - test_errors);
	endtask

	initial begin
		void'($urandom(32'h26e9));
		clk_i = 1'b0;
		arst_n_i = 1'b0;
		rn_req_i = '0;
		cm_req_i = '0;
		flush_i = 1'b0;
		checks = 0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		hung = 1'b0;
		recover = 1'b0;
		for (int i = 0; i < `RALLOC_ARCH_N; i++) begin
			spec_map[i] = `RALLOC_PHY_CW'(i);
			cm_map[i] = `RALLOC_PHY_CW'(i);
		end
		spec_busy = {{(`RALLOC_PHY_N-`RALLOC_ARCH_N){1'b0}}, {`RALLOC_ARCH_N{1'b1}}};
		cm_busy = spec_busy;
		repeat (16) @(posedge clk_i);
		arst_n_i <= 1'b1;

		open_test("reset_identity");
		rename(5'd5);
		close_test();

		open_test("fill_until_full");
		n = 0;
		while (lowest_free(spec_busy) >= 0 && n < 40) begin
			rename(5'($urandom_range(30, 0) + 1));
			n++;
		end
		rename(5'd9); // dropped under back-pressure
		close_test();

		open_test("commit_frees_old");
		commit_oldest();
		wait_ready(8);
		if (!hung) rename(5'($urandom_range(30, 0) + 1));
		close_test();

		if (!hung) begin
			open_test("flush_restore");
			repeat (4) commit_oldest();
			wait_ready(8);
			if (!hung) begin
				rename(5'd3);
				rename(5'd4);
				step(1'b1, 5'd7, 1'b0, '0, '0, 1'b1); // rename in the flush cycle
				rename(5'd3); // recover cycle
				for (int r = 1; r < 16; r++) rename(5'(r));
			end
			close_test();
		end

		if (!hung) begin
			open_test("rd_zero_bypass");
			rename(5'd0);
			rename(5'd11);
			close_test();
		end

		if (!hung) begin
			open_test("random_mix");
			for (int c = 0; c < 500; c++) begin
				if (rob_rd.size() > 0 && $urandom_range(1, 0) == 1) begin
					step(1'($urandom_range(1, 0)), 5'($urandom_range(31, 0)), 1'b1,
						rob_rd.pop_front(), rob_phy.pop_front(), 1'b0);
				end else begin
					step(1'($urandom_range(1, 0)), 5'($urandom_range(31, 0)), 1'b0, '0, '0, 1'b0);
				end
			end
			close_test();
		end

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed_tests, checks, errors);
		if (errors == 0 && !hung) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- verification/ralloc_chk.sv
`timescale 1ns/1ns
`include "ralloc_macros.svh"

module ralloc_chk import ralloc_pkg::*; (
	input logic clk_i,
	input logic arst_n_i,
	input rn_req_t rn_req_i,
	input rn_rsp_t rn_rsp_o,
	input cm_req_t cm_req_i,
	input logic flush_i,
	input logic rn_ready_o
);

	a_ack_needs_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rn_rsp_o.ack |-> rn_ready_o)
		else $error("acknowledge given while rn_ready_o is low");

	a_ack_needs_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		rn_rsp_o.ack |-> rn_req_i.valid)
		else $error("acknowledge given without a rename request");

	// the recover cycle blocks renaming
	a_flush_recover: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		flush_i |=> !rn_ready_o)
		else $error("rn_ready_o high in the cycle after a flush");

	a_no_commit_on_flush: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		!(cm_req_i.valid && flush_i))
		else $error("commit and flush in the same cycle");

endmodule

bind ralloc_top ralloc_chk u_chk (.*);

//--- hdl/ralloc_top.sv
`timescale 1ns/1ns
`include "ralloc_macros.svh"

module ralloc_top import ralloc_pkg::*; (
	input logic clk_i,
	input logic arst_n_i,
	input rn_req_t rn_req_i,
	output rn_rsp_t rn_rsp_o,
	input cm_req_t cm_req_i,
	input logic flush_i,
	output logic rn_ready_o
);

	bm_op_e bm_op;
	logic map_wr, restore, ack, full;
	logic [`RALLOC_PHY_CW-1:0] phy_new, pos, phy_old_spec, phy_old_cm;
	logic [`RALLOC_PHY_N-1:0] busy_spec;

	ralloc_ctrl u_ctrl (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .rn_req_i(rn_req_i), .flush_i(flush_i),
		.full_i(full), .pos_i(pos), .bm_op_o(bm_op), .map_wr_o(map_wr),
		.restore_o(restore), .ack_o(ack), .phy_new_o(phy_new), .rn_ready_o(rn_ready_o)
	);

	busy_bitmap u_bitmap (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .bm_op_i(bm_op), .alloc_idx_i(phy_new),
		.free_en_i(cm_req_i.valid), .free_idx_i(phy_old_cm),
		.cm_en_i(cm_req_i.valid), .cm_idx_i(cm_req_i.phy_new), .busy_spec_o(busy_spec)
	);

	rename_table u_table (
		.clk_i(clk_i), .arst_n_i(arst_n_i), .rd_spec_i(rn_req_i.rd), .map_wr_i(map_wr),
		.phy_wr_i(phy_new), .cm_i(cm_req_i), .restore_i(restore),
		.phy_old_spec_o(phy_old_spec), .phy_old_cm_o(phy_old_cm)
	);

	// empty can never happen with the architectural registers always mapped
	lzp #(.CW(`RALLOC_PHY_CW)) u_lzp (
		.in_i(busy_spec), .pos_o(pos), .full_o(full), .empty_o()
	);

	assign rn_rsp_o = '{ack: ack, phy_new: phy_new, phy_old: phy_old_spec};

endmodule

//--- hdl/ralloc_ctrl.sv
`timescale 1ns/1ns
`include "ralloc_macros.svh"

module ralloc_ctrl import ralloc_pkg::*; (
	input logic clk_i,
	input logic arst_n_i,
	input rn_req_t rn_req_i,
	input logic flush_i,
	input logic full_i,
	input logic [`RALLOC_PHY_CW-1:0] pos_i,
	output bm_op_e bm_op_o,
	output logic map_wr_o,
	output logic restore_o,
	output logic ack_o,
	output logic [`RALLOC_PHY_CW-1:0] phy_new_o,
	output logic rn_ready_o
);

	ctrl_state_e state_q, state_n;
	logic rd_zero;
	logic alloc;

	assign state_n = flush_i ? ST_RECOVER : ST_RUN; // one recover cycle unless flushed again

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= ST_RUN;
		end else begin
			state_q <= state_n;
		end
	end

	assign rn_ready_o = (state_q == ST_RUN) && !full_i && !flush_i;
	assign ack_o = rn_req_i.valid && rn_ready_o;

	// x0 is never renamed, it gets phy 0 and consumes nothing
	assign rd_zero = (rn_req_i.rd == '0);
	assign alloc = ack_o && !rd_zero;
	assign phy_new_o = rd_zero ? '0 : pos_i;

	always_comb begin
		if (flush_i) begin
			bm_op_o = BM_RESTORE; // flush wins over any rename in the same cycle
		end else if (alloc) begin
			bm_op_o = BM_ALLOC;
		end else begin
			bm_op_o = BM_HOLD;
		end
	end

	assign map_wr_o = alloc;
	assign restore_o = flush_i;

endmodule

//--- hdl/rename_table.sv
`timescale 1ns/1ns
`include "ralloc_macros.svh"

module rename_table import ralloc_pkg::*; (
	input logic clk_i,
	input logic arst_n_i,
	input logic [`RALLOC_ARCH_CW-1:0] rd_spec_i,
	input logic map_wr_i,
	input logic [`RALLOC_PHY_CW-1:0] phy_wr_i,
	input cm_req_t cm_i,
	input logic restore_i,
	output logic [`RALLOC_PHY_CW-1:0] phy_old_spec_o,
	output logic [`RALLOC_PHY_CW-1:0] phy_old_cm_o
);

	logic [`RALLOC_PHY_CW-1:0] spec_map_q [`RALLOC_ARCH_N];
	logic [`RALLOC_PHY_CW-1:0] cm_map_q [`RALLOC_ARCH_N];
	logic [`RALLOC_PHY_CW-1:0] cm_map_n [`RALLOC_ARCH_N];

	always_comb begin
		cm_map_n = cm_map_q;
		if (cm_i.valid) begin
			cm_map_n[cm_i.rd] = cm_i.phy_new;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `RALLOC_ARCH_N; i++) begin
				cm_map_q[i] <= `RALLOC_PHY_CW'(i); // arch i lives in phy i
			end
		end else begin
			cm_map_q <= cm_map_n;
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 0; i < `RALLOC_ARCH_N; i++) begin
				spec_map_q[i] <= `RALLOC_PHY_CW'(i);
			end
		end else if (restore_i) begin
			spec_map_q <= cm_map_n; // whole table rolls back to the committed view
		end else if (map_wr_i) begin
			spec_map_q[rd_spec_i] <= phy_wr_i;
		end
	end

	assign phy_old_spec_o = spec_map_q[rd_spec_i];

	// this is the register that becomes free once the commit lands
	assign phy_old_cm_o = cm_map_q[cm_i.rd];

endmodule

//--- hdl/busy_bitmap.sv
`timescale 1ns/1ns
`include "ralloc_macros.svh"

module busy_bitmap import ralloc_pkg::*; (
	input logic clk_i,
	input logic arst_n_i,
	input bm_op_e bm_op_i,
	input logic [`RALLOC_PHY_CW-1:0] alloc_idx_i,
	input logic free_en_i,
	input logic [`RALLOC_PHY_CW-1:0] free_idx_i,
	input logic cm_en_i,
	input logic [`RALLOC_PHY_CW-1:0] cm_idx_i,
	output logic [`RALLOC_PHY_N-1:0] busy_spec_o
);

	// the identity mapping keeps the low registers busy out of reset
	localparam logic [`RALLOC_PHY_N-1:0] RST_BUSY =
		{{(`RALLOC_PHY_N-`RALLOC_ARCH_N){1'b0}}, {`RALLOC_ARCH_N{1'b1}}};

	logic [`RALLOC_PHY_N-1:0] spec_q, spec_n;
	logic [`RALLOC_PHY_N-1:0] cm_q, cm_n;
	logic free_hit;

	// a commit that writes back the same register it replaced (x0) frees nothing
	assign free_hit = free_en_i && !(cm_en_i && (free_idx_i == cm_idx_i));

	always_comb begin
		cm_n = cm_q;
		if (free_hit) cm_n[free_idx_i] = 1'b0;
		if (cm_en_i) cm_n[cm_idx_i] = 1'b1;
	end

	always_comb begin
		spec_n = spec_q;
		case (bm_op_i)
			BM_ALLOC: spec_n[alloc_idx_i] = 1'b1;
			BM_RESTORE: spec_n = cm_n; // drops every uncommitted allocation
			default: spec_n = spec_q;
		endcase
		if (free_hit) spec_n[free_idx_i] = 1'b0;
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			spec_q <= RST_BUSY;
			cm_q <= RST_BUSY;
		end else begin
			spec_q <= spec_n;
			cm_q <= cm_n;
		end
	end

	assign busy_spec_o = spec_q;

endmodule

//--- hdl/lzp.sv
`timescale 1ns/1ns

module lzp #(
	parameter int CW = 6,
	parameter int DW = 2**CW
) (
	input logic [DW-1:0] in_i,
	output logic [CW-1:0] pos_o,
	output logic full_o,
	output logic empty_o
);

	localparam int PW = 2**CW;

	logic [PW-1:0] padded;
	logic [2*PW-1:1] ones; // heap of all-ones flags, node n has children 2n and 2n+1
	logic [CW:0] node;

	always_comb begin
		padded = '1; // missing high inputs count as busy
		padded[DW-1:0] = in_i;
	end

	assign ones[2*PW-1:PW] = padded;

	// each level pairs up the one below it, root ends up at node 1
	generate
		for (genvar n = 1; n < PW; n++) begin : g_tree
			assign ones[n] = ones[2*n] & ones[2*n+1];
		end
	endgenerate

	// walk down from the root, taking the left child while it still has a zero
	always_comb begin
		node = 1;
		for (int l = 0; l < CW; l++) begin
			node = {node[CW-1:0], ones[{node, 1'b0}]};
		end
	end

	assign pos_o = node[CW-1:0]; // leaf index minus PW
	assign full_o = ones[1];
	assign empty_o = ~|in_i;

endmodule

//--- hdl/ralloc_pkg.sv
`include "ralloc_macros.svh"

package ralloc_pkg;

	typedef struct packed {
		logic valid;
		logic [`RALLOC_ARCH_CW-1:0] rd;
	} rn_req_t;

	typedef struct packed {
		logic ack;
		logic [`RALLOC_PHY_CW-1:0] phy_new; // register handed out this cycle
		logic [`RALLOC_PHY_CW-1:0] phy_old; // mapping it replaces, kept by the ROB
	} rn_rsp_t;

	typedef struct packed {
		logic valid;
		logic [`RALLOC_ARCH_CW-1:0] rd;
		logic [`RALLOC_PHY_CW-1:0] phy_new;
	} cm_req_t;

	typedef enum logic {
		ST_RUN,
		ST_RECOVER
	} ctrl_state_e;

	// freeing at commit has its own strobe since it can overlap BM_ALLOC
	typedef enum logic [1:0] {
		BM_HOLD,
		BM_ALLOC,
		BM_RESTORE
	} bm_op_e;

endpackage

//--- hdl/ralloc_macros.svh
`ifndef RALLOC_MACROS_SVH
`define RALLOC_MACROS_SVH

// physical register file
`define RALLOC_PHY_CW 6
`define RALLOC_PHY_N 64

// architectural registers, x0 included
`define RALLOC_ARCH_CW 5
`define RALLOC_ARCH_N 32

`endif
